// ==== hdl/muldiv_pkg.sv ====
// Word types, opcode and APB state enums, register map and pipeline constants.
`default_nettype none

package muldiv_pkg;

    // Datapath word width.
    localparam int WORD_W = 32;

    // Operand or result word.
    typedef logic [WORD_W-1:0] word_t;
    // Full product.
    typedef logic [2*WORD_W-1:0] dword_t;
    // APB byte address.
    typedef logic [7:0] apb_addr_t;
    // In-flight operation count.
    typedef logic [2:0] inflight_t;

    // Operation codes, same values as RISC-V funct3.
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } md_op_t;

    // APB slave states.
    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        ACCESS      = 2'd1,
        WAIT_RESULT = 2'd2
    } apb_state_t;

    // Register map.
    localparam apb_addr_t ADDR_LHS    = 8'h00;
    localparam apb_addr_t ADDR_RHS    = 8'h04;
    // Write an opcode here to launch.
    localparam apb_addr_t ADDR_CMD    = 8'h08;
    localparam apb_addr_t ADDR_RESULT = 8'h0C;
    localparam apb_addr_t ADDR_STATUS = 8'h10;

    // One pipeline register per this many divider bit stages.
    localparam int DIV_REG_SPACING = 8;
    // Registered divider stages.
    localparam int DIV_STAGE_REGS = WORD_W / DIV_REG_SPACING;
    // Sign register, stage registers, output register.
    localparam int MD_LATENCY = 1 + DIV_STAGE_REGS + 1;
    // Saturation limit of the in-flight counter.
    localparam int MAX_IN_FLIGHT = 7;

endpackage

`default_nettype wire

// ==== hdl/div_stage.sv ====
// One restoring division bit step with an optional input register.
`default_nettype none

module div_stage #(
    // Quotient bit produced here.
    parameter int exponent = 0,
    // Register the inputs first.
    parameter bit has_reg  = 1'b0
) (
    input  logic              clk,
    input  muldiv_pkg::word_t divisor,
    input  muldiv_pkg::word_t rem_in,
    input  muldiv_pkg::word_t quot_in,
    output muldiv_pkg::word_t divisor_out,
    output muldiv_pkg::word_t rem_out,
    output muldiv_pkg::word_t quot_out
);
    import muldiv_pkg::*;

    word_t  divisor_r;
    word_t  rem_r;
    word_t  quot_r;
    // Divisor aligned to this bit, wide so no bits drop.
    dword_t shifted;
    logic   fits;

    generate
        if (has_reg) begin : g_reg
            // Pipeline register, payload only.
            always_ff @(posedge clk) begin
                divisor_r <= divisor;
                rem_r     <= rem_in;
                quot_r    <= quot_in;
            end
        end else begin : g_pass
            assign divisor_r = divisor;
            assign rem_r     = rem_in;
            assign quot_r    = quot_in;
        end
    endgenerate

    assign shifted = dword_t'(divisor_r) << exponent;

    // Remainder not smaller than shifted divisor.
    assign fits = dword_t'(rem_r) >= shifted;

    // Shifted value is below 2^32 whenever it fits.
    assign rem_out = fits ? rem_r - shifted[WORD_W-1:0] : rem_r;

    // Set this quotient bit, keep the rest.
    always_comb begin
        quot_out           = quot_r;
        quot_out[exponent] = fits;
    end

    assign divisor_out = divisor_r;

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
// Signed/unsigned 32x32 multiplier with a product delay chain matched to the divider.
`default_nettype none

module mul_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  muldiv_pkg::md_op_t op,
    input  muldiv_pkg::word_t  lhs,
    input  muldiv_pkg::word_t  rhs,
    output muldiv_pkg::dword_t product
);
    import muldiv_pkg::*;

    logic   lhs_signed;
    logic   rhs_signed;
    dword_t lhs_ext;
    dword_t rhs_ext;
    dword_t full;
    // Product chain, one slot per cycle of latency.
    dword_t prod_q [MD_LATENCY];
    // Marks slots holding a fresh product.
    logic [MD_LATENCY-2:0] vld_q;

    // MULH signs both, MULHSU only lhs.
    assign lhs_signed = (op == MULH) || (op == MULHSU);
    assign rhs_signed = (op == MULH);

    // Extend to 64 bits so one unsigned multiply covers all cases.
    assign lhs_ext = {{WORD_W{lhs_signed & lhs[WORD_W-1]}}, lhs};
    assign rhs_ext = {{WORD_W{rhs_signed & rhs[WORD_W-1]}}, rhs};

    // Low 64 bits of the product are exact for either signedness.
    assign full = lhs_ext * rhs_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MD_LATENCY-3:0], start};
        end
    end

    // Slots only move when they carry a new product.
    always_ff @(posedge clk) begin
        if (start) begin
            prod_q[0] <= full;
        end
        for (int i = 1; i < MD_LATENCY; i++) begin
            if (vld_q[i-1]) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    // Last slot lines up with the divider output register.
    assign product = prod_q[MD_LATENCY-1];

endmodule

`default_nettype wire

// ==== hdl/div_pipe.sv ====
// Pipelined signed/unsigned restoring divider with sign correction and divide-by-zero rules.
`default_nettype none

module div_pipe (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  muldiv_pkg::md_op_t op,
    input  muldiv_pkg::word_t  lhs,
    input  muldiv_pkg::word_t  rhs,
    output muldiv_pkg::word_t  quotient,
    output muldiv_pkg::word_t  remainder
);
    import muldiv_pkg::*;

    logic  signed_op;
    logic  lhs_neg;
    logic  rhs_neg;
    word_t lhs_mag;
    word_t rhs_mag;
    // Input register.
    word_t dvd_q;
    word_t dvs_q;
    logic  neg_quot_q;
    logic  neg_rem_q;
    logic  dz_q;
    logic  vld_q;
    // Flags riding next to the stage registers.
    logic [DIV_STAGE_REGS-1:0] neg_quot_d;
    logic [DIV_STAGE_REGS-1:0] neg_rem_d;
    logic [DIV_STAGE_REGS-1:0] dz_d;
    logic [DIV_STAGE_REGS-1:0] vld_d;
    // Stage interconnect.
    word_t div_c [WORD_W+1];
    word_t rem_c [WORD_W+1];
    word_t quot_c [WORD_W+1];

    // Only DIV and REM treat operands as signed.
    assign signed_op = (op == DIV) || (op == REM);
    assign lhs_neg   = signed_op && lhs[WORD_W-1];
    assign rhs_neg   = signed_op && rhs[WORD_W-1];
    assign lhs_mag   = lhs_neg ? -lhs : lhs;
    assign rhs_mag   = rhs_neg ? -rhs : rhs;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
            vld_d <= '0;
        end else begin
            vld_q <= start;
            vld_d <= {vld_d[DIV_STAGE_REGS-2:0], vld_q};
        end
    end

    // Magnitudes and flags, loaded on launch.
    always_ff @(posedge clk) begin
        if (start) begin
            dvd_q      <= lhs_mag;
            dvs_q      <= rhs_mag;
            neg_quot_q <= lhs_neg ^ rhs_neg;
            neg_rem_q  <= lhs_neg;
            dz_q       <= (rhs == '0);
        end
    end

    // Shift every cycle, like the stage registers.
    always_ff @(posedge clk) begin
        neg_quot_d <= {neg_quot_d[DIV_STAGE_REGS-2:0], neg_quot_q};
        neg_rem_d  <= {neg_rem_d[DIV_STAGE_REGS-2:0], neg_rem_q};
        dz_d       <= {dz_d[DIV_STAGE_REGS-2:0], dz_q};
    end

    assign div_c[0]  = dvs_q;
    assign rem_c[0]  = dvd_q;
    assign quot_c[0] = '0;

    // MSB first; registers sit mid-group so every segment is at most 8 bits deep.
    generate
        for (genvar i = 0; i < WORD_W; i++) begin : g_stage
            div_stage #(
                .exponent(WORD_W - 1 - i),
                .has_reg((i % DIV_REG_SPACING) == (DIV_REG_SPACING / 2))
            ) u_stage (
                .clk        (clk),
                .divisor    (div_c[i]),
                .rem_in     (rem_c[i]),
                .quot_in    (quot_c[i]),
                .divisor_out(div_c[i+1]),
                .rem_out    (rem_c[i+1]),
                .quot_out   (quot_c[i+1])
            );
        end
    endgenerate

    // Output register with sign correction.
    // A zero divisor leaves the dividend magnitude as remainder, so the sign fix restores it.
    always_ff @(posedge clk) begin
        if (vld_d[DIV_STAGE_REGS-1]) begin
            if (dz_d[DIV_STAGE_REGS-1]) begin
                quotient <= '1;
            end else if (neg_quot_d[DIV_STAGE_REGS-1]) begin
                quotient <= -quot_c[WORD_W];
            end else begin
                quotient <= quot_c[WORD_W];
            end
            // Remainder follows the dividend sign.
            remainder <= neg_rem_d[DIV_STAGE_REGS-1] ? -rem_c[WORD_W] : rem_c[WORD_W];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/result_merge.sv ====
// Opcode and valid delay line with final result selection.
`default_nettype none

module result_merge (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  muldiv_pkg::md_op_t op,
    input  muldiv_pkg::dword_t product,
    input  muldiv_pkg::word_t  quotient,
    input  muldiv_pkg::word_t  remainder,
    output muldiv_pkg::word_t  result,
    output logic               result_valid
);
    import muldiv_pkg::*;

    // Launch marker, one bit per cycle of latency.
    logic [MD_LATENCY-1:0] vld_q;
    // Opcode travelling with it.
    md_op_t op_q [MD_LATENCY];
    md_op_t op_out;

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MD_LATENCY-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        op_q[0] <= op;
        for (int i = 1; i < MD_LATENCY; i++) begin
            op_q[i] <= op_q[i-1];
        end
    end

    assign op_out       = op_q[MD_LATENCY-1];
    assign result_valid = vld_q[MD_LATENCY-1];

    // Pick the datapath output for the delayed opcode.
    always_comb begin
        case (op_out)
            MUL: begin
                result = product[WORD_W-1:0];
            end
            MULH, MULHSU, MULHU: begin
                result = product[2*WORD_W-1:WORD_W];
            end
            DIV, DIVU: begin
                result = quotient;
            end
            // REM and REMU.
            default: begin
                result = remainder;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/muldiv_apb.sv ====
// APB slave with operand, command, result and status registers and an in-flight counter.
`default_nettype none

module muldiv_apb (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  muldiv_pkg::apb_addr_t paddr,
    input  muldiv_pkg::word_t     pwdata,
    output muldiv_pkg::word_t     prdata,
    output logic                  pready,
    output logic                  pslverr,
    output muldiv_pkg::word_t     lhs,
    output muldiv_pkg::word_t     rhs,
    output muldiv_pkg::md_op_t    op,
    output logic                  start,
    input  muldiv_pkg::word_t     result,
    input  logic                  result_valid
);
    import muldiv_pkg::*;

    apb_state_t state_q;
    apb_state_t state_d;
    md_op_t     op_q;
    word_t      result_q;
    inflight_t  count_q;
    logic       busy;
    logic       mapped;
    logic       read_only;
    logic       result_read;
    logic       in_access;
    logic       done;
    word_t      status;

    assign busy = (count_q != '0);

    // Address decode.
    assign mapped = paddr inside {ADDR_LHS, ADDR_RHS, ADDR_CMD, ADDR_RESULT, ADDR_STATUS};
    assign read_only   = (paddr == ADDR_RESULT) || (paddr == ADDR_STATUS);
    assign result_read = !pwrite && (paddr == ADDR_RESULT);

    // Access phase, including the stalled result read.
    assign in_access = psel && penable && (state_q == ACCESS || state_q == WAIT_RESULT);

    // Result reads wait for the pipeline to drain.
    assign pready = !(in_access && result_read && busy);

    // Completing cycle of a transfer.
    assign done = in_access && pready;

    // Errors only on the completing cycle.
    assign pslverr = done && (!mapped || (pwrite && read_only));

    // Launch in the cycle the CMD write completes.
    assign start = done && pwrite && (paddr == ADDR_CMD);

    // New opcode is presented in the launch cycle itself.
    assign op = start ? md_op_t'(pwdata[2:0]) : op_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // Setup phase.
                if (psel && !penable) begin
                    state_d = ACCESS;
                end
            end
            ACCESS: begin
                if (in_access && !pready) begin
                    state_d = WAIT_RESULT;
                end else begin
                    state_d = IDLE;
                end
            end
            WAIT_RESULT: begin
                // Leave once drained or if the host gives up.
                if (!busy || !psel) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Writable registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            lhs  <= '0;
            rhs  <= '0;
            op_q <= MUL;
        end else if (done && pwrite) begin
            case (paddr)
                ADDR_LHS: lhs  <= pwdata;
                ADDR_RHS: rhs  <= pwdata;
                ADDR_CMD: op_q <= md_op_t'(pwdata[2:0]);
                default: ;
            endcase
        end
    end

    // Newest completed result only.
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (result_valid) begin
            result_q <= result;
        end
    end

    // In-flight count, saturating at the limit.
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            case ({start, result_valid})
                2'b10: begin
                    if (count_q != inflight_t'(MAX_IN_FLIGHT)) begin
                        count_q <= count_q + 1'b1;
                    end
                end
                2'b01: begin
                    if (busy) begin
                        count_q <= count_q - 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Busy in bit 0, count in bits 3:1.
    assign status = word_t'({count_q, busy});

    // Read data mux.
    always_comb begin
        case (paddr)
            ADDR_LHS:    prdata = lhs;
            ADDR_RHS:    prdata = rhs;
            ADDR_CMD:    prdata = word_t'(op_q);
            ADDR_RESULT: prdata = result_q;
            ADDR_STATUS: prdata = status;
            default:     prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/muldiv_top.sv ====
// Top level joining the APB slave, multiplier, divider and result merge.
`default_nettype none

module muldiv_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  muldiv_pkg::apb_addr_t paddr,
    input  muldiv_pkg::word_t     pwdata,
    output muldiv_pkg::word_t     prdata,
    output logic                  pready,
    output logic                  pslverr
);
    import muldiv_pkg::*;

    // Launch bus from the slave.
    word_t  lhs;
    word_t  rhs;
    md_op_t op;
    logic   start;
    // Datapath outputs.
    dword_t product;
    word_t  quotient;
    word_t  remainder;
    // Merged result back to the slave.
    word_t  result;
    logic   result_valid;

    muldiv_apb u_apb (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .lhs         (lhs),
        .rhs         (rhs),
        .op          (op),
        .start       (start),
        .result      (result),
        .result_valid(result_valid)
    );

    mul_unit u_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .lhs    (lhs),
        .rhs    (rhs),
        .product(product)
    );

    div_pipe u_div (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .op       (op),
        .lhs      (lhs),
        .rhs      (rhs),
        .quotient (quotient),
        .remainder(remainder)
    );

    result_merge u_merge (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .op          (op),
        .product     (product),
        .quotient    (quotient),
        .remainder   (remainder),
        .result      (result),
        .result_valid(result_valid)
    );

endmodule

`default_nettype wire

// ==== testbench/muldiv_properties.sv ====
// Concurrent checks on the APB handshake, error flag, address stability and result latency.
`default_nettype none

module muldiv_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  psel,
    input logic                  penable,
    input logic                  pwrite,
    input muldiv_pkg::apb_addr_t paddr,
    input logic                  pready,
    input logic                  pslverr,
    input logic                  start,
    input logic                  result_valid
);
    timeunit 1ns;
    timeprecision 1ps;
    import muldiv_pkg::*;

    // The one access that may be held off.
    logic result_read;
    // Recent launches, newest in bit 0.
    logic [MD_LATENCY-1:0] start_hist;

    assign result_read = !pwrite && (paddr == ADDR_RESULT);

    always_ff @(posedge clk) begin
        if (rst) begin
            start_hist <= '0;
        end else begin
            start_hist <= {start_hist[MD_LATENCY-2:0], start};
        end
    end

    // Only a RESULT read may stall, and only behind a launch still in the pipeline.
    stall_bounded: assert property (
        @(posedge clk) disable iff (rst)
        !pready |-> (result_read && (start_hist != '0))
    ) else $error("pready low without a RESULT read behind a recent launch");

    // A stalled access stays in the access phase until pready.
    stall_held: assert property (
        @(posedge clk) disable iff (rst)
        (psel && penable && !pready) |=> (psel && penable)
    ) else $error("access phase left while pready was low");

    // Error flag only on a completing cycle straight after setup.
    slverr_with_ready: assert property (
        @(posedge clk) disable iff (rst)
        pslverr |-> (pready && $past(psel && !penable))
    ) else $error("pslverr outside the first completing access cycle");

    // Address frozen from setup to completion.
    addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (psel && !(penable && pready)) |=> $stable(paddr)
    ) else $error("paddr changed inside a transfer");

    // Every launch returns exactly MD_LATENCY cycles later.
    valid_after_start: assert property (
        @(posedge clk) disable iff (rst)
        $past(start, MD_LATENCY) |-> result_valid
    ) else $error("result_valid missing after start");

    // No result without a matching launch.
    start_before_valid: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |-> $past(start, MD_LATENCY)
    ) else $error("result_valid without a start");

endmodule

`default_nettype wire

// ==== testbench/muldiv_tb.sv ====
// Testbench top: clock, reset, APB tasks, golden file replay, checks and timeout.
`default_nettype none

module muldiv_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import muldiv_pkg::*;

    // Records in the golden file, four words each.
    localparam int NUM_TESTS = 38;
    localparam int RESET_CYCLES = 5;
    // Three writes and one stalled read per record.
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (MD_LATENCY + 12) + RESET_CYCLES;
    // DIVU record used for the stall test.
    localparam int STALL_REC = 25;

    logic      clk = 1'b0;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    // Op, lhs, rhs, expected.
    word_t       golden [NUM_TESTS*4];
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    word_t       rdata;
    logic        err;
    int          stalls;
    int          rec_a;
    int          rec_b;

    muldiv_top uut (
        .clk    (clk),
        .rst    (rst),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    bind muldiv_apb muldiv_properties u_props (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pready      (pready),
        .pslverr     (pslverr),
        .start       (start),
        .result_valid(result_valid)
    );

    always #20 clk = ~clk;

    // Run limit.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit.
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED: %s expected %08h actual %08h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR: %s", what);
            $display("TEST RESULT: FAIL");
            $fatal(1, "protocol error");
        end
    endtask

    // Setup, then access until pready; returns with the bus still owned.
    // The next posedge completes the transfer.
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                                output word_t data, output logic slverr, output int waits);
        waits = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        data   = prdata;
        slverr = pslverr;
    endtask

    task automatic release_bus();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input word_t data);
        word_t ignored;
        logic  slverr;
        int    waits;
        apb_transfer(1'b1, addr, data, ignored, slverr, waits);
        require(!slverr, $sformatf("write to %02h flagged pslverr", addr));
    endtask

    task automatic read_reg(input apb_addr_t addr, output word_t data, output int waits);
        logic slverr;
        apb_transfer(1'b0, addr, '0, data, slverr, waits);
        require(!slverr, $sformatf("read of %02h flagged pslverr", addr));
    endtask

    task automatic run_record(input int idx);
        word_t result;
        int    waits;
        write_reg(ADDR_LHS, golden[4*idx+1]);
        write_reg(ADDR_RHS, golden[4*idx+2]);
        write_reg(ADDR_CMD, golden[4*idx]);
        read_reg(ADDR_RESULT, result, waits);
        check_value($sformatf("record %0d op %0d", idx, golden[4*idx][2:0]),
                    golden[4*idx+3], result);
    endtask

    initial begin
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = 32'hb392;
        $readmemh("testbench/muldiv_golden.hex", golden);
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Golden records in file order.
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_record(i);
        end
        release_bus();

        // RESULT straight after CMD must stall.
        write_reg(ADDR_LHS, golden[4*STALL_REC+1]);
        write_reg(ADDR_RHS, golden[4*STALL_REC+2]);
        write_reg(ADDR_CMD, golden[4*STALL_REC]);
        read_reg(ADDR_RESULT, rdata, stalls);
        require(stalls > 0, "RESULT read right after CMD was not held off");
        check_value("stalled result", golden[4*STALL_REC+3], rdata);
        // Busy flag while in flight, clear after.
        write_reg(ADDR_CMD, golden[4*STALL_REC]);
        read_reg(ADDR_STATUS, rdata, stalls);
        check_value("status busy bit", 32'h1, rdata & 32'h1);
        read_reg(ADDR_RESULT, rdata, stalls);
        read_reg(ADDR_STATUS, rdata, stalls);
        check_value("status after drain", 32'h0, rdata);
        release_bus();

        // Two launches with new operands between, pairs picked by the LFSR.
        for (int pair = 0; pair < 2; pair++) begin
            take_bits(6, rec_a);
            take_bits(6, rec_b);
            rec_a = rec_a % NUM_TESTS;
            rec_b = rec_b % NUM_TESTS;
            write_reg(ADDR_LHS, golden[4*rec_a+1]);
            write_reg(ADDR_RHS, golden[4*rec_a+2]);
            write_reg(ADDR_CMD, golden[4*rec_a]);
            write_reg(ADDR_LHS, golden[4*rec_b+1]);
            write_reg(ADDR_RHS, golden[4*rec_b+2]);
            write_reg(ADDR_CMD, golden[4*rec_b]);
            read_reg(ADDR_RESULT, rdata, stalls);
            check_value($sformatf("back to back %0d then %0d", rec_a, rec_b),
                        golden[4*rec_b+3], rdata);
            read_reg(ADDR_STATUS, rdata, stalls);
            check_value("status after back to back", 32'h0, rdata);
            release_bus();
        end

        // Bad accesses flag pslverr and leave registers alone.
        write_reg(ADDR_LHS, 32'h5a5a5a5a);
        apb_transfer(1'b1, 8'h14, 32'hdeadbeef, rdata, err, stalls);
        require(err, "write to unmapped address 14 completed without pslverr");
        apb_transfer(1'b0, 8'h40, '0, rdata, err, stalls);
        require(err, "read of unmapped address 40 completed without pslverr");
        apb_transfer(1'b1, ADDR_RESULT, 32'hdeadbeef, rdata, err, stalls);
        require(err, "write to RESULT completed without pslverr");
        apb_transfer(1'b1, ADDR_STATUS, 32'hdeadbeef, rdata, err, stalls);
        require(err, "write to STATUS completed without pslverr");
        read_reg(ADDR_LHS, rdata, stalls);
        check_value("lhs after bad accesses", 32'h5a5a5a5a, rdata);
        read_reg(ADDR_RESULT, rdata, stalls);
        check_value("result after RESULT write", golden[4*rec_b+3], rdata);
        release_bus();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/muldiv_golden.hex ====
// Columns: opcode (funct3), lhs, rhs, expected result; all hex, one test per line.
// Opcodes: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU.
0 00000007 00000006 0000002a
0 ffffffff ffffffff 00000001
0 12345678 00000010 23456780
0 80000000 00000002 00000000
0 0000ffff 0000ffff fffe0001
1 ffffffff ffffffff 00000000
1 80000000 80000000 40000000
1 80000000 00000002 ffffffff
1 7fffffff 7fffffff 3fffffff
1 00010000 00010000 00000001
2 ffffffff ffffffff ffffffff
2 80000000 ffffffff 80000000
2 00000002 ffffffff 00000001
2 fffffffe 00000003 ffffffff
3 ffffffff ffffffff fffffffe
3 80000000 00000002 00000001
3 00010000 00020000 00000002
3 00000007 00000006 00000000
4 00000014 00000006 00000003
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
4 80000000 ffffffff 80000000
4 00000005 00000000 ffffffff
4 00000000 00000003 00000000
5 ffffffec 00000006 2aaaaaa7
5 80000000 ffffffff 00000000
5 00000064 00000000 ffffffff
5 ffffffff 00000001 ffffffff
6 00000014 00000006 00000002
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
6 ffffffec fffffffa fffffffe
6 80000000 ffffffff 00000000
6 fffffff9 00000000 fffffff9
7 ffffffec 00000006 00000002
7 00000064 00000000 00000064
7 0000000d 00000004 00000001

// ==== tb.f ====
hdl/muldiv_pkg.sv
hdl/div_stage.sv
hdl/mul_unit.sv
hdl/div_pipe.sv
hdl/result_merge.sv
hdl/muldiv_apb.sv
hdl/muldiv_top.sv
testbench/muldiv_properties.sv
testbench/muldiv_tb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the muldiv testbench.

TOP := muldiv_tb

.PHONY: all lint clean

# Build and run; a $fatal in the run gives a failing exit status.
all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir
